/* source/axi_read_pkg.sv */
package axi_read_pkg;

  // Channel field widths
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;

  // Beat count minus one
  typedef logic [7:0] len_t;

  typedef logic [1:0] resp_t;

  // Response codes used by the guard
  localparam resp_t RespOkay   = 2'b00;
  localparam resp_t RespSlvErr = 2'b10;

endpackage

/* source/guard_pkg.sv */
package guard_pkg;

  // Cause of the first fault seen since reset
  typedef enum logic [2:0] {
    FaultNone     = 3'd0,
    FaultMismatch = 3'd1,
    FaultArStall  = 3'd2,
    FaultArToR    = 3'd3,
    FaultRToLast  = 3'd4
  } fault_cause_e;

  // Phase of a transaction slot
  typedef enum logic [1:0] {
    PhaseFree = 2'd0,
    PhaseAddr = 2'd1,
    PhaseData = 2'd2
  } slot_phase_e;

endpackage

/* source/txn_tracker.sv */
`timescale 1ns/1ps

module txn_tracker #(
  parameter int unsigned MaxTxns = 4,
  parameter int unsigned MaxIds  = 4,
  localparam int unsigned SlotW  = (MaxTxns > 1) ? $clog2(MaxTxns) : 1
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              push_i,
  input  axi_read_pkg::id_t push_id_i,
  input  logic              lookup_i,
  input  axi_read_pkg::id_t lookup_id_i,
  input  logic              pop_i,
  output logic              full_o,
  output logic [SlotW-1:0]  push_slot_o,
  output logic              hit_o,
  output logic [SlotW-1:0]  hit_slot_o
);
  import axi_read_pkg::*;

  localparam int unsigned HtW = (MaxIds > 1) ? $clog2(MaxIds) : 1;

  // Head-tail table, one entry per ID with reads outstanding
  logic [MaxIds-1:0]  ht_free_q, ht_free_d;
  id_t                ht_id_q   [MaxIds];
  id_t                ht_id_d   [MaxIds];
  logic [SlotW-1:0]   ht_head_q [MaxIds];
  logic [SlotW-1:0]   ht_head_d [MaxIds];
  logic [SlotW-1:0]   ht_tail_q [MaxIds];
  logic [SlotW-1:0]   ht_tail_d [MaxIds];

  // Slot pool, linked per ID in acceptance order
  logic [MaxTxns-1:0] slot_free_q, slot_free_d;
  logic [SlotW-1:0]   slot_next_q [MaxTxns];
  logic [SlotW-1:0]   slot_next_d [MaxTxns];

  logic [MaxIds-1:0]  lookup_match, push_match;
  logic [HtW-1:0]     lookup_idx, push_idx, ht_free_idx, open_idx;
  logic [SlotW-1:0]   slot_free_idx;
  logic               pop, ht_emptied, push_hit, append;

  // Parallel ID compare against live entries
  always_comb begin
    for (int i = 0; i < MaxIds; i++) begin
      lookup_match[i] = !ht_free_q[i] && (ht_id_q[i] == lookup_id_i);
      push_match[i]   = !ht_free_q[i] && (ht_id_q[i] == push_id_i);
    end
  end

  // Lowest index wins in every search
  always_comb begin
    lookup_idx    = '0;
    push_idx      = '0;
    ht_free_idx   = '0;
    slot_free_idx = '0;
    for (int i = MaxIds - 1; i >= 0; i--) begin
      if (lookup_match[i]) begin
        lookup_idx = HtW'(i);
      end
      if (push_match[i]) begin
        push_idx = HtW'(i);
      end
      if (ht_free_q[i]) begin
        ht_free_idx = HtW'(i);
      end
    end
    for (int i = MaxTxns - 1; i >= 0; i--) begin
      if (slot_free_q[i]) begin
        slot_free_idx = SlotW'(i);
      end
    end
  end

  assign hit_o      = lookup_i && (|lookup_match);
  assign hit_slot_o = ht_head_q[lookup_idx];
  assign pop        = pop_i && hit_o;
  assign ht_emptied = pop && (ht_head_q[lookup_idx] == ht_tail_q[lookup_idx]);
  assign push_hit   = |push_match;

  // An ID whose only read is popped this cycle gets its entry reopened
  assign append   = push_hit && !(ht_emptied && (push_idx == lookup_idx));
  assign open_idx = push_hit ? push_idx : ((|ht_free_q) ? ht_free_idx : lookup_idx);

  // A slot freed by a pop in the same cycle can take the push
  assign push_slot_o = (|slot_free_q) ? slot_free_idx : hit_slot_o;
  assign full_o      = !(((|slot_free_q) || pop) &&
                         ((|ht_free_q) || ht_emptied || push_hit));

  always_comb begin
    ht_free_d   = ht_free_q;
    ht_id_d     = ht_id_q;
    ht_head_d   = ht_head_q;
    ht_tail_d   = ht_tail_q;
    slot_free_d = slot_free_q;
    slot_next_d = slot_next_q;

    // Unlink the head of the returning ID
    if (pop) begin
      slot_free_d[hit_slot_o] = 1'b1;
      if (ht_emptied) begin
        ht_free_d[lookup_idx] = 1'b1;
      end else begin
        ht_head_d[lookup_idx] = slot_next_q[hit_slot_o];
      end
    end

    if (push_i) begin
      slot_free_d[push_slot_o] = 1'b0;
      if (append) begin
        slot_next_d[ht_tail_q[push_idx]] = push_slot_o;
        ht_tail_d[push_idx]              = push_slot_o;
      end else begin
        ht_free_d[open_idx] = 1'b0;
        ht_id_d[open_idx]   = push_id_i;
        ht_head_d[open_idx] = push_slot_o;
        ht_tail_d[open_idx] = push_slot_o;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ht_free_q   <= '1;
      slot_free_q <= '1;
    end else begin
      ht_free_q   <= ht_free_d;
      slot_free_q <= slot_free_d;
    end
  end

  always_ff @(posedge clk_i) begin
    ht_id_q     <= ht_id_d;
    ht_head_q   <= ht_head_d;
    ht_tail_q   <= ht_tail_d;
    slot_next_q <= slot_next_d;
  end

endmodule

/* source/slot_timers.sv */
`timescale 1ns/1ps

module slot_timers #(
  parameter int unsigned MaxTxns  = 4,
  parameter int unsigned CntWidth = 8,
  localparam int unsigned SlotW   = (MaxTxns > 1) ? $clog2(MaxTxns) : 1
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     push_i,
  input  logic [SlotW-1:0]         push_slot_i,
  input  axi_read_pkg::id_t        push_id_i,
  input  logic                     beat_i,
  input  logic [SlotW-1:0]         beat_slot_i,
  input  logic                     pop_i,
  input  logic [CntWidth-1:0]      budget_ar_r_i,
  input  logic [CntWidth-1:0]      budget_r_last_i,
  output logic                     timeout_o,
  output guard_pkg::fault_cause_e  timeout_cause_o,
  output axi_read_pkg::id_t        timeout_id_o
);
  import axi_read_pkg::*;
  import guard_pkg::*;

  slot_phase_e         phase_q [MaxTxns];
  id_t                 id_q    [MaxTxns];
  logic [CntWidth-1:0] cnt_q   [MaxTxns];
  logic [MaxTxns-1:0]  at_budget;

  // Budget depends on which phase the slot is in
  always_comb begin
    for (int i = 0; i < MaxTxns; i++) begin
      case (phase_q[i])
        PhaseAddr: at_budget[i] = (cnt_q[i] == budget_ar_r_i);
        PhaseData: at_budget[i] = (cnt_q[i] == budget_r_last_i);
        default:   at_budget[i] = 1'b0;
      endcase
    end
  end

  // Report the lowest slot that ran out
  always_comb begin
    timeout_o       = 1'b0;
    timeout_cause_o = FaultNone;
    timeout_id_o    = '0;
    for (int i = MaxTxns - 1; i >= 0; i--) begin
      if (at_budget[i]) begin
        timeout_o       = 1'b1;
        timeout_cause_o = (phase_q[i] == PhaseAddr) ? FaultArToR : FaultRToLast;
        timeout_id_o    = id_q[i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < MaxTxns; i++) begin
        phase_q[i] <= PhaseFree;
        cnt_q[i]   <= '0;
      end
    end else begin
      for (int i = 0; i < MaxTxns; i++) begin
        if (push_i && (push_slot_i == SlotW'(i))) begin
          phase_q[i] <= PhaseAddr;
          cnt_q[i]   <= '0;
        end else if (pop_i && (beat_slot_i == SlotW'(i))) begin
          phase_q[i] <= PhaseFree;
        end else if (beat_i && (beat_slot_i == SlotW'(i)) && (phase_q[i] == PhaseAddr)) begin
          // First beat starts the burst timer
          phase_q[i] <= PhaseData;
          cnt_q[i]   <= '0;
        end else if ((phase_q[i] != PhaseFree) && !at_budget[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < MaxTxns; i++) begin
      if (push_i && (push_slot_i == SlotW'(i))) begin
        id_q[i] <= push_id_i;
      end
    end
  end

endmodule

/* source/fault_ctrl.sv */
`timescale 1ns/1ps

module fault_ctrl #(
  parameter int unsigned CntWidth = 8
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     ar_valid_i,
  input  logic                     ar_ready_i,
  input  axi_read_pkg::id_t        ar_id_i,
  input  logic                     full_i,
  input  logic                     r_xfer_i,
  input  logic                     hit_i,
  input  axi_read_pkg::id_t        r_id_i,
  input  logic                     timeout_i,
  input  guard_pkg::fault_cause_e  timeout_cause_i,
  input  axi_read_pkg::id_t        timeout_id_i,
  input  logic [CntWidth-1:0]      budget_ar_stall_i,
  output logic                     ar_pass_o,
  output logic                     reset_req_o,
  output logic                     irq_o,
  output guard_pkg::fault_cause_e  fault_cause_o,
  output axi_read_pkg::id_t        fault_id_o
);
  import axi_read_pkg::*;
  import guard_pkg::*;

  logic [CntWidth-1:0] stall_q;
  logic                stalled, stall_fault, mismatch;
  logic                fault;
  fault_cause_e        cause_d;
  id_t                 id_d;

  assign stalled     = ar_valid_i && !ar_ready_i;
  assign stall_fault = stalled && (stall_q == budget_ar_stall_i);
  assign mismatch    = r_xfer_i && !hit_i;

  // Priority: mismatch, then AR stall, then slot timeout
  always_comb begin
    fault   = 1'b1;
    cause_d = FaultNone;
    id_d    = '0;
    if (mismatch) begin
      cause_d = FaultMismatch;
      id_d    = r_id_i;
    end else if (stall_fault) begin
      cause_d = FaultArStall;
      id_d    = ar_id_i;
    end else if (timeout_i) begin
      cause_d = timeout_cause_i;
      id_d    = timeout_id_i;
    end else begin
      fault = 1'b0;
    end
  end

  // Consecutive cycles of AR valid without ready
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stall_q <= '0;
    end else if (!stalled) begin
      stall_q <= '0;
    end else if (!stall_fault) begin
      stall_q <= stall_q + 1'b1;
    end
  end

  // Only the first fault is recorded
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reset_req_o   <= 1'b0;
      irq_o         <= 1'b0;
      fault_cause_o <= FaultNone;
      fault_id_o    <= '0;
    end else begin
      irq_o <= 1'b0;
      if (fault && !reset_req_o) begin
        reset_req_o   <= 1'b1;
        irq_o         <= 1'b1;
        fault_cause_o <= cause_d;
        fault_id_o    <= id_d;
      end
    end
  end

  assign ar_pass_o = !full_i && !reset_req_o;

endmodule

/* source/read_guard_top.sv */
`timescale 1ns/1ps

module read_guard_top #(
  parameter int unsigned MaxTxns  = 4,
  parameter int unsigned MaxIds   = 4,
  parameter int unsigned CntWidth = 8
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Manager side
  input  logic                     m_ar_valid_i,
  output logic                     m_ar_ready_o,
  input  axi_read_pkg::id_t        m_ar_id_i,
  input  axi_read_pkg::addr_t      m_ar_addr_i,
  input  axi_read_pkg::len_t       m_ar_len_i,
  output logic                     m_r_valid_o,
  input  logic                     m_r_ready_i,
  output axi_read_pkg::id_t        m_r_id_o,
  output axi_read_pkg::data_t      m_r_data_o,
  output axi_read_pkg::resp_t      m_r_resp_o,
  output logic                     m_r_last_o,
  // Subordinate side
  output logic                     s_ar_valid_o,
  input  logic                     s_ar_ready_i,
  output axi_read_pkg::id_t        s_ar_id_o,
  output axi_read_pkg::addr_t      s_ar_addr_o,
  output axi_read_pkg::len_t       s_ar_len_o,
  input  logic                     s_r_valid_i,
  output logic                     s_r_ready_o,
  input  axi_read_pkg::id_t        s_r_id_i,
  input  axi_read_pkg::data_t      s_r_data_i,
  input  axi_read_pkg::resp_t      s_r_resp_i,
  input  logic                     s_r_last_i,
  // Budgets in cycles
  input  logic [CntWidth-1:0]      budget_ar_stall_i,
  input  logic [CntWidth-1:0]      budget_ar_r_i,
  input  logic [CntWidth-1:0]      budget_r_last_i,
  output logic                     reset_req_o,
  output logic                     irq_o,
  output guard_pkg::fault_cause_e  fault_cause_o,
  output axi_read_pkg::id_t        fault_id_o
);
  import axi_read_pkg::*;
  import guard_pkg::*;

  localparam int unsigned SlotW = (MaxTxns > 1) ? $clog2(MaxTxns) : 1;

  logic             ar_pass, ar_xfer, r_xfer, r_pop;
  logic             full, hit, timeout;
  logic [SlotW-1:0] push_slot, hit_slot;
  fault_cause_e     timeout_cause;
  id_t              timeout_id;

  // AR is held back while the pool is full or after a fault
  assign s_ar_valid_o = m_ar_valid_i && ar_pass;
  assign m_ar_ready_o = s_ar_ready_i && ar_pass;
  assign s_ar_id_o    = m_ar_id_i;
  assign s_ar_addr_o  = m_ar_addr_i;
  assign s_ar_len_o   = m_ar_len_i;
  assign ar_xfer      = s_ar_valid_o && s_ar_ready_i;

  assign m_r_valid_o = s_r_valid_i;
  assign s_r_ready_o = m_r_ready_i;
  assign m_r_id_o    = s_r_id_i;
  assign m_r_data_o  = s_r_data_i;
  assign m_r_last_o  = s_r_last_i;
  assign m_r_resp_o  = reset_req_o ? RespSlvErr : s_r_resp_i;
  assign r_xfer      = s_r_valid_i && m_r_ready_i;
  assign r_pop       = r_xfer && s_r_last_i;

  txn_tracker #(
    .MaxTxns (MaxTxns),
    .MaxIds  (MaxIds)
  ) tracker0 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (ar_xfer),
    .push_id_i   (m_ar_id_i),
    .lookup_i    (r_xfer),
    .lookup_id_i (s_r_id_i),
    .pop_i       (r_pop),
    .full_o      (full),
    .push_slot_o (push_slot),
    .hit_o       (hit),
    .hit_slot_o  (hit_slot)
  );

  slot_timers #(
    .MaxTxns  (MaxTxns),
    .CntWidth (CntWidth)
  ) timers0 (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .push_i          (ar_xfer),
    .push_slot_i     (push_slot),
    .push_id_i       (m_ar_id_i),
    .beat_i          (hit),
    .beat_slot_i     (hit_slot),
    .pop_i           (r_pop && hit),
    .budget_ar_r_i   (budget_ar_r_i),
    .budget_r_last_i (budget_r_last_i),
    .timeout_o       (timeout),
    .timeout_cause_o (timeout_cause),
    .timeout_id_o    (timeout_id)
  );

  fault_ctrl #(
    .CntWidth (CntWidth)
  ) fault0 (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .ar_valid_i        (s_ar_valid_o),
    .ar_ready_i        (s_ar_ready_i),
    .ar_id_i           (m_ar_id_i),
    .full_i            (full),
    .r_xfer_i          (r_xfer),
    .hit_i             (hit),
    .r_id_i            (s_r_id_i),
    .timeout_i         (timeout),
    .timeout_cause_i   (timeout_cause),
    .timeout_id_i      (timeout_id),
    .budget_ar_stall_i (budget_ar_stall_i),
    .ar_pass_o         (ar_pass),
    .reset_req_o       (reset_req_o),
    .irq_o             (irq_o),
    .fault_cause_o     (fault_cause_o),
    .fault_id_o        (fault_id_o)
  );

endmodule

/* tests/read_guard_properties.sv */
`timescale 1ns/1ps

module read_guard_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic irq_o,
  input logic reset_req_o,
  input logic m_ar_ready_o
);

  // Interrupt is a single-cycle pulse
  irq_single_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni) irq_o |=> !irq_o
  ) else $error("irq_o stayed high for more than one cycle");

  // Reset request only clears through reset
  reset_req_sticky: assert property (
    @(posedge clk_i) disable iff (!rst_ni) reset_req_o |=> reset_req_o
  ) else $error("reset_req_o fell without a reset");

  // No AR is accepted once a fault is latched
  ar_blocked_after_fault: assert property (
    @(posedge clk_i) disable iff (!rst_ni) reset_req_o |-> !m_ar_ready_o
  ) else $error("m_ar_ready_o high while reset_req_o is set");

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int unsigned PeriodNs    = 40,
  parameter int unsigned ResetCycles = 4
) (
  input  logic rst_req_i,
  output logic clk_o,
  output logic rst_no
);

  // Rising edges left before reset is released
  int unsigned hold = ResetCycles;

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  always @(posedge clk_o) begin
    if (rst_req_i) begin
      hold <= ResetCycles;
    end else if (hold != 0) begin
      hold <= hold - 1;
    end
  end

  // Reset changes on the falling edge, away from the DUT's clock edge
  always @(negedge clk_o) begin
    rst_no <= (hold == 0);
  end

endmodule

/* tests/read_guard_tb.sv */
`timescale 1ns/1ps

module read_guard_tb;
  import axi_read_pkg::*;
  import guard_pkg::*;

  localparam int unsigned WaitLimit = 200;

  logic clk, rst_n, rst_req;
  logic m_ar_valid, m_ar_ready_o, m_r_valid_o, m_r_ready, m_r_last_o;
  logic s_ar_valid_o, s_ar_ready, s_r_valid, s_r_ready_o, s_r_last;
  id_t m_ar_id, m_r_id_o, s_ar_id_o, s_r_id, fault_id_o;
  addr_t m_ar_addr, s_ar_addr_o;
  len_t m_ar_len, s_ar_len_o;
  data_t m_r_data_o, s_r_data;
  resp_t m_r_resp_o, s_r_resp;
  logic [7:0] budget_ar_stall, budget_ar_r, budget_r_last;
  logic reset_req_o, irq_o;
  fault_cause_e fault_cause_o;
  int unsigned error_count;
  bit verdict_printed;
  id_t ids [4];
  len_t lens [4];

  tb_clock #(.PeriodNs(40), .ResetCycles(4)) clk_gen0 (
    .rst_req_i (rst_req),
    .clk_o     (clk),
    .rst_no    (rst_n)
  );

  read_guard_top dut0 (
    .clk_i (clk), .rst_ni (rst_n),
    .m_ar_valid_i (m_ar_valid), .m_ar_ready_o (m_ar_ready_o), .m_ar_id_i (m_ar_id),
    .m_ar_addr_i (m_ar_addr), .m_ar_len_i (m_ar_len),
    .m_r_valid_o (m_r_valid_o), .m_r_ready_i (m_r_ready), .m_r_id_o (m_r_id_o),
    .m_r_data_o (m_r_data_o), .m_r_resp_o (m_r_resp_o), .m_r_last_o (m_r_last_o),
    .s_ar_valid_o (s_ar_valid_o), .s_ar_ready_i (s_ar_ready), .s_ar_id_o (s_ar_id_o),
    .s_ar_addr_o (s_ar_addr_o), .s_ar_len_o (s_ar_len_o),
    .s_r_valid_i (s_r_valid), .s_r_ready_o (s_r_ready_o), .s_r_id_i (s_r_id),
    .s_r_data_i (s_r_data), .s_r_resp_i (s_r_resp), .s_r_last_i (s_r_last),
    .budget_ar_stall_i (budget_ar_stall), .budget_ar_r_i (budget_ar_r),
    .budget_r_last_i (budget_r_last),
    .reset_req_o (reset_req_o), .irq_o (irq_o),
    .fault_cause_o (fault_cause_o), .fault_id_o (fault_id_o)
  );

  bind read_guard_top read_guard_properties props0 (
    .clk_i (clk_i), .rst_ni (rst_ni), .irq_o (irq_o),
    .reset_req_o (reset_req_o), .m_ar_ready_o (m_ar_ready_o)
  );

  task automatic stop_on_error();
    verdict_printed = 1'b1;
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic fail_now(input string what);
    error_count++;
    $display("%s", what);
    stop_on_error();
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      fail_now($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      fail_now($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_len(input string name, input len_t got, input len_t exp);
    if (got !== exp) begin
      fail_now($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_resp(input string name, input resp_t got, input resp_t exp);
    if (got !== exp) begin
      fail_now($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_cause(input string name, input fault_cause_e got,
                             input fault_cause_e exp);
    if (got !== exp) begin
      fail_now($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_id(input string name, input id_t got, input id_t exp);
    if (got !== exp) begin
      fail_now($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic drive_idle();
    m_ar_valid = 1'b0;
    m_ar_id    = '0;
    m_ar_addr  = '0;
    m_ar_len   = '0;
    m_r_ready  = 1'b1;
    s_ar_ready = 1'b1;
    s_r_valid  = 1'b0;
    s_r_id     = '0;
    s_r_data   = '0;
    s_r_resp   = RespOkay;
    s_r_last   = 1'b0;
  endtask

  task automatic reset_dut();
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    drive_idle();
    rst_req = 1'b1;
    @(negedge clk);
    rst_req = 1'b0;
    #1;
    while (!rst_n) begin
      if (waited == WaitLimit) begin
        fail_now("Reset was never released");
      end
      @(negedge clk);
      #1;
      waited++;
    end
  endtask

  // Manager side: hold AR valid until the guard takes it
  task automatic send_ar(input id_t id, input len_t len);
    int unsigned waited;
    addr_t addr;
    waited = 0;
    addr   = $urandom;
    @(negedge clk);
    m_ar_valid = 1'b1;
    m_ar_id    = id;
    m_ar_addr  = addr;
    m_ar_len   = len;
    #1;
    while (!m_ar_ready_o) begin
      if (waited == WaitLimit) begin
        fail_now("AR request was never accepted");
      end
      @(negedge clk);
      #1;
      waited++;
    end
    check_flag("s_ar_valid_o", s_ar_valid_o, 1'b1);
    check_id("s_ar_id_o", s_ar_id_o, id);
    check_addr("s_ar_addr_o", s_ar_addr_o, addr);
    check_len("s_ar_len_o", s_ar_len_o, len);
    @(negedge clk);
    m_ar_valid = 1'b0;
  endtask

  // AR offered for a few cycles while the guard must refuse it
  task automatic offer_blocked_ar(input id_t id, input int unsigned cycles);
    @(negedge clk);
    m_ar_valid = 1'b1;
    m_ar_id    = id;
    for (int unsigned c = 0; c < cycles; c++) begin
      #1;
      check_flag("m_ar_ready_o", m_ar_ready_o, 1'b0);
      check_flag("s_ar_valid_o", s_ar_valid_o, 1'b0);
      @(negedge clk);
    end
    m_ar_valid = 1'b0;
  endtask

  // Subordinate side: one burst of len+1 beats, manager always ready
  task automatic send_r(input id_t id, input len_t len, input resp_t exp_resp);
    data_t beat;
    for (int b = 0; b <= int'(len); b++) begin
      @(negedge clk);
      beat      = $urandom;
      s_r_valid = 1'b1;
      s_r_id    = id;
      s_r_data  = beat;
      s_r_resp  = RespOkay;
      s_r_last  = (b == int'(len));
      #1;
      check_flag("m_r_valid_o", m_r_valid_o, 1'b1);
      check_flag("s_r_ready_o", s_r_ready_o, 1'b1);
      check_flag("m_r_last_o", m_r_last_o, (b == int'(len)));
      check_data("m_r_data_o", m_r_data_o, beat);
      check_resp("m_r_resp_o", m_r_resp_o, exp_resp);
      check_id("m_r_id_o", m_r_id_o, id);
    end
    @(negedge clk);
    s_r_valid = 1'b0;
    s_r_last  = 1'b0;
  endtask

  task automatic expect_no_fault();
    #1;
    check_flag("reset_req_o", reset_req_o, 1'b0);
    check_cause("fault_cause_o", fault_cause_o, FaultNone);
  endtask

  task automatic wait_fault(input fault_cause_e exp_cause, input id_t exp_id);
    int unsigned waited;
    waited = 0;
    #1;
    while (!reset_req_o) begin
      if (waited == WaitLimit) begin
        fail_now("Expected fault was never raised");
      end
      @(negedge clk);
      #1;
      waited++;
    end
    check_flag("irq_o", irq_o, 1'b1);
    check_cause("fault_cause_o", fault_cause_o, exp_cause);
    check_id("fault_id_o", fault_id_o, exp_id);
    @(negedge clk);
    #1;
    check_flag("irq_o", irq_o, 1'b0);
    check_flag("reset_req_o", reset_req_o, 1'b1);
  endtask

  task automatic test_in_order();
    reset_dut();
    for (int i = 0; i < 3; i++) begin
      ids[i]  = id_t'($urandom);
      lens[i] = len_t'($urandom % 3);
      send_ar(ids[i], lens[i]);
    end
    for (int i = 0; i < 3; i++) begin
      send_r(ids[i], lens[i], RespOkay);
    end
    expect_no_fault();
  endtask

  task automatic test_full_pool();
    reset_dut();
    for (int i = 0; i < 4; i++) begin
      ids[i] = id_t'($urandom);
      send_ar(ids[i], '0);
    end
    offer_blocked_ar(id_t'($urandom), 5);
    send_r(ids[0], '0, RespOkay);
    send_ar(id_t'($urandom), '0);
    expect_no_fault();
  endtask

  task automatic test_out_of_order();
    id_t base;
    reset_dut();
    base = id_t'($urandom);
    send_ar(base, 8'd1);
    send_ar(base + 1, 8'd0);
    send_ar(base, 8'd0);
    send_ar(base + 2, 8'd1);
    send_r(base + 2, 8'd1, RespOkay);
    send_r(base, 8'd1, RespOkay);
    send_r(base + 1, 8'd0, RespOkay);
    send_r(base, 8'd0, RespOkay);
    expect_no_fault();
  endtask

  task automatic test_mismatch();
    id_t good;
    reset_dut();
    good = id_t'($urandom);
    send_ar(good, '0);
    send_r(good + 5, '0, RespOkay);
    wait_fault(FaultMismatch, good + 5);
    send_r(good, '0, RespSlvErr);
    offer_blocked_ar(good, 5);
  endtask

  task automatic test_ar_to_r();
    id_t id;
    reset_dut();
    id = id_t'($urandom);
    send_ar(id, '0);
    wait_fault(FaultArToR, id);
  endtask

  task automatic test_ar_stall();
    id_t id;
    reset_dut();
    id = id_t'($urandom);
    @(negedge clk);
    s_ar_ready = 1'b0;
    m_ar_valid = 1'b1;
    m_ar_id    = id;
    wait_fault(FaultArStall, id);
  endtask

  initial begin
    void'($urandom(90));
    error_count     = 0;
    verdict_printed = 1'b0;
    rst_req         = 1'b0;
    budget_ar_stall = 8'd6;
    budget_ar_r     = 8'd20;
    budget_r_last   = 8'd20;
    drive_idle();
    test_in_order();
    test_full_pool();
    test_out_of_order();
    test_mismatch();
    test_ar_to_r();
    test_ar_stall();
    verdict_printed = 1'b1;
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // A run stopped by a failed assertion ends here
  final begin
    if (!verdict_printed) begin
      $display("Done: errors found");
    end
  end

endmodule

/* all.f */
source/axi_read_pkg.sv
source/guard_pkg.sv
source/txn_tracker.sv
source/slot_timers.sv
source/fault_ctrl.sv
source/read_guard_top.sv
tests/read_guard_properties.sv
tests/tb_clock.sv
tests/read_guard_tb.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= all.f
RTL_TOP   ?= read_guard_top
TB_TOP    ?= read_guard_tb
BUILD_DIR ?= build
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
